//--- mem_router_input.txt
# kind addr we vbk svbk brlo bank expect offset wr_en (hex; expect is a source or a byte)
R 0000 0 00 00 00 0 BOOT 0000 000
R 0800 0 00 00 00 0 BOOT 0800 000
R 0150 0 00 00 00 0 CART 0150 000
R 0900 0 00 00 00 0 CART 0900 000
R 0000 0 00 00 01 0 CART 0000 000
R 8123 0 00 00 01 0 VRAM0 0123 000
R 9FFF 0 01 00 01 0 VRAM1 1FFF 000
R A010 0 00 00 01 0 EXT0 0010 000
R A010 0 00 00 01 1 EXT1 0010 000
R B000 0 00 00 01 2 EXT2 1000 000
R BFFF 0 00 00 01 3 EXT3 1FFF 000
R D123 0 00 00 01 0 WRAM1 0123 000
R D123 0 00 01 01 0 WRAM1 0123 000
R D200 0 00 02 01 0 WRAM2 0200 000
R D3FF 0 00 03 01 0 WRAM3 03FF 000
R D400 0 00 04 01 0 WRAM4 0400 000
R D5A5 0 00 05 01 0 WRAM5 05A5 000
R DE00 0 00 06 01 0 WRAM6 0E00 000
R DFFF 0 00 07 01 0 WRAM7 0FFF 000
R F123 0 00 03 01 0 WRAM3 0123 000
R FF00 0 00 00 01 0 11 FF00 000
R FF0F 0 00 00 01 0 12 FF0F 000
R FF40 0 00 00 01 0 13 FF40 000
R FF41 0 00 00 01 0 14 FF41 000
R FF42 0 00 00 01 0 15 FF42 000
R FF43 0 00 00 01 0 16 FF43 000
R FF44 0 00 00 01 0 17 FF44 000
R FF45 0 00 00 01 0 18 FF45 000
R FF4A 0 00 00 01 0 19 FF4A 000
R FF4B 0 00 00 01 0 1A FF4B 000
R FF4F 0 03 00 01 0 03 FF4F 000
R FF50 0 00 00 5A 0 5A FF50 000
R FF51 0 00 00 01 0 21 FF51 000
R FF52 0 00 00 01 0 22 FF52 000
R FF53 0 00 00 01 0 23 FF53 000
R FF54 0 00 00 01 0 24 FF54 000
R FF55 0 00 00 01 0 25 FF55 000
R FF68 0 00 00 01 0 26 FF68 000
R FF69 0 00 00 01 0 BGPAL FF69 000
R FF6A 0 00 00 01 0 27 FF6A 000
R FF6B 0 00 00 01 0 OBJPAL FF6B 000
R FF70 0 00 06 01 0 06 FF70 000
R FF10 0 00 00 01 0 OPEN FF10 000
R FEA5 0 00 00 01 0 OPEN 0005 000
R FF85 0 00 00 01 0 HRAM 0005 000
R FFFF 0 00 00 01 0 IE 0000 000
W 8000 1 00 00 01 0 - 0000 200
W 9ABC 1 01 00 01 0 - 1ABC 400
W C000 1 00 00 01 0 - 0000 002
W D000 1 00 00 01 0 - 0000 004
W D000 1 00 01 01 0 - 0000 004
W D000 1 00 02 01 0 - 0000 008
W D000 1 00 03 01 0 - 0000 010
W D000 1 00 04 01 0 - 0000 020
W D000 1 00 05 01 0 - 0000 040
W D000 1 00 06 01 0 - 0000 080
W D000 1 00 07 01 0 - 0000 100
W FF90 1 00 00 01 0 - 0010 001
W 0150 1 00 00 01 0 - 0150 000
W E010 1 00 00 01 0 - 0010 000
W FE10 1 00 00 01 0 - 0010 000
W FFFF 1 00 00 01 0 - 0000 000
W C000 0 00 00 01 0 - 0000 000

//--- project.f
mem_map_pkg.sv
region_decoder.sv
io_reg_read.sv
read_data_mux.sv
write_enable_decoder.sv
mem_router_top.sv
tb_mem_router.sv

//--- tb_mem_router.sv
`timescale 1ns/1ps

module tb_mem_router;

	import mem_map_pkg::*;

	localparam int RESET_TIMEOUT = 50; // cycles
	localparam int MAX_LINES     = 200;
	localparam int MIN_VECTORS   = 60;

	localparam logic [7:0] BOOT_PAT      = 8'hB0;
	localparam logic [7:0] CART_PAT      = 8'hC7;
	localparam logic [7:0] VRAM_PAT_BASE = 8'h90; // plus bank number
	localparam logic [7:0] EXT_PAT_BASE  = 8'hA0;
	localparam logic [7:0] WRAM_PAT_BASE = 8'h60;
	localparam logic [7:0] OAM_PAT       = 8'hE5;
	localparam logic [7:0] HRAM_PAT      = 8'h8F;
	localparam logic [7:0] BGPAL_PAT     = 8'h3C;
	localparam logic [7:0] OBJPAL_PAT    = 8'h4D;
	localparam logic [7:0] IE_PAT        = 8'h2F;

	logic              clk4_2;
	logic              reset_n;
	logic [ADDR_W-1:0] addr;
	logic              addr_latch;
	logic              mem_we;
	logic [1:0]        ext_ram_bank_sel;
	io_regs_t          regs;
	mem_rd_data_t      rd_src;
	logic [DATA_W-1:0] data_out;
	mem_wr_en_t        wr_en;
	logic [ADDR_W-1:0] addr_offset;

	int data_errs   = 0;
	int offset_errs = 0;
	int wr_en_errs  = 0;
	int other_errs  = 0;
	int vectors     = 0;

	// one parsed line of the vector file
	logic [8*128-1:0] line;
	logic [63:0]      kind;
	logic [63:0]      expect_tok;
	logic [15:0]      v_addr;
	logic [15:0]      v_off;
	logic [15:0]      v_wen;
	logic [7:0]       v_we;
	logic [7:0]       v_vbk;
	logic [7:0]       v_svbk;
	logic [7:0]       v_brlo;
	logic [7:0]       v_ext;

	mem_router_top #(
		.BOOT_ROM_LAST_PAGE (8)
	) mem_router_top_inst (
		.clk4_2           (clk4_2),
		.reset_n          (reset_n),
		.addr             (addr),
		.addr_latch       (addr_latch),
		.mem_we           (mem_we),
		.ext_ram_bank_sel (ext_ram_bank_sel),
		.regs             (regs),
		.rd_src           (rd_src),
		.data_out         (data_out),
		.wr_en            (wr_en),
		.addr_offset      (addr_offset)
	);

	always #20 clk4_2 = ~clk4_2;

	initial begin
		reset_n = 1'b0;
		repeat (5) @(posedge clk4_2);
		reset_n <= 1'b1;
	end

	// ascii hex digit to {valid, nibble}
	function automatic logic [4:0] hex_nibble(input logic [7:0] c);
		logic [7:0] d;
		d = 8'h00;
		if (c >= "0" && c <= "9")
			d = c - "0" + 8'h10;
		else if (c >= "A" && c <= "F")
			d = c - "A" + 8'h1A;
		return d[4:0];
	endfunction

	// source name or two hex digits to {valid, byte}
	function automatic logic [8:0] expected_byte(input logic [63:0] tok);
		logic [7:0] idx;
		logic [4:0] hi;
		logic [4:0] lo;
		idx = tok[7:0] - "0";
		hi = hex_nibble(tok[15:8]);
		lo = hex_nibble(tok[7:0]);
		case (tok)
			"BOOT":   return {1'b1, BOOT_PAT};
			"CART":   return {1'b1, CART_PAT};
			"OAM":    return {1'b1, OAM_PAT};
			"HRAM":   return {1'b1, HRAM_PAT};
			"BGPAL":  return {1'b1, BGPAL_PAT};
			"OBJPAL": return {1'b1, OBJPAL_PAT};
			"IE":     return {1'b1, IE_PAT};
			"OPEN":   return 9'h1FF;
			default:  ;
		endcase
		if (tok[63:8] == "VRAM")
			return {1'b1, VRAM_PAT_BASE + idx};
		if (tok[63:8] == "EXT")
			return {1'b1, EXT_PAT_BASE + idx};
		if (tok[63:8] == "WRAM")
			return {1'b1, WRAM_PAT_BASE + idx};
		if (tok[63:16] == '0 && hi[4] && lo[4])
			return {1'b1, hi[3:0], lo[3:0]};
		return 9'h000;
	endfunction

	task automatic wait_reset(output bit released);
		int cycles;
		cycles = 0;
		while (reset_n !== 1'b1 && cycles < RESET_TIMEOUT) begin
			@(posedge clk4_2);
			cycles++;
		end
		released = (reset_n === 1'b1);
	endtask

	task automatic apply_vector();
		logic [8:0] exp_byte;
		exp_byte = expected_byte(expect_tok);
		vectors++;
		@(posedge clk4_2);
		addr             <= v_addr;
		addr_latch       <= (kind == "R");
		mem_we           <= v_we[0];
		ext_ram_bank_sel <= v_ext[1:0];
		regs.vbk         <= v_vbk;
		regs.svbk        <= v_svbk;
		regs.brlo        <= v_brlo;
		if (kind == "R") begin
			@(posedge clk4_2); // latching edge
			addr_latch <= 1'b0;
			@(negedge clk4_2);
			if (!exp_byte[8]) begin
				other_errs++;
				$display("vector file names an unknown expected source for address %h", v_addr);
			end
			else begin
				assert (data_out === exp_byte[7:0]) else begin
					data_errs++;
					$display("ERROR %0t: read of %h gave %h, expected %h (%0s)", $time, v_addr,
						data_out, exp_byte[7:0], expect_tok);
				end
			end
		end
		else begin
			@(negedge clk4_2);
			assert (wr_en === v_wen[10:0]) else begin
				wr_en_errs++;
				$display("ERROR %0t: write to %h gave wr_en %h, expected %h", $time, v_addr,
					wr_en, v_wen[10:0]);
			end
		end
		assert (addr_offset === v_off) else begin
			offset_errs++;
			$display("ERROR %0t: offset of %h is %h, expected %h", $time, v_addr, addr_offset, v_off);
		end
	endtask

	task automatic run_vectors();
		integer fd;
		integer cnt;
		int     lines;
		fd = $fopen("mem_router_input.txt", "r");
		if (fd == 0) begin
			other_errs++;
			$display("could not open the vector file mem_router_input.txt");
			return;
		end
		lines = 0;
		while (!$feof(fd) && lines < MAX_LINES) begin
			lines++;
			line = '0;
			kind = '0;
			cnt = $fgets(line, fd);
			cnt = $sscanf(line, "%s %h %h %h %h %h %h %s %h %h", kind, v_addr, v_we, v_vbk,
				v_svbk, v_brlo, v_ext, expect_tok, v_off, v_wen);
			if (cnt == 10 && kind != "#")
				apply_vector();
			else if (cnt > 0 && kind != "#") begin
				other_errs++;
				$display("vector file line %0d could not be parsed", lines);
			end
		end
		if (!$feof(fd)) begin
			other_errs++;
			$display("vector file still not at its end after %0d lines", MAX_LINES);
		end
		$fclose(fd);
		if (vectors < MIN_VECTORS) begin
			other_errs++;
			$display("vector file is short: %0d vectors, at least %0d expected", vectors, MIN_VECTORS);
		end
	endtask

	initial begin
		bit released;
		clk4_2           = 1'b0;
		addr             = '0;
		addr_latch       = 1'b0;
		mem_we           = 1'b0;
		ext_ram_bank_sel = '0;
		regs = '{joyp: 8'h11, int_flag: 8'h12, lcdc: 8'h13, stat: 8'h14, scy: 8'h15,
			scx: 8'h16, ly: 8'h17, lyc: 8'h18, wy: 8'h19, wx: 8'h1A, vbk: 8'h00,
			brlo: 8'h00, hdma1: 8'h21, hdma2: 8'h22, hdma3: 8'h23, hdma4: 8'h24,
			hdma5: 8'h25, bcps: 8'h26, ocps: 8'h27, svbk: 8'h00, ie: IE_PAT};
		rd_src.boot_rom    = BOOT_PAT;
		rd_src.cart_rom    = CART_PAT;
		rd_src.oam         = OAM_PAT;
		rd_src.hram        = HRAM_PAT;
		rd_src.bg_palette  = BGPAL_PAT;
		rd_src.obj_palette = OBJPAL_PAT;
		for (int i = 0; i < 2; i++)
			rd_src.vram[i] = VRAM_PAT_BASE + i;
		for (int i = 0; i < 4; i++)
			rd_src.ext_ram[i] = EXT_PAT_BASE + i;
		for (int i = 0; i < 8; i++)
			rd_src.wram[i] = WRAM_PAT_BASE + i;

		wait_reset(released);
		if (!released) begin
			$display("reset_n was still low after %0d cycles", RESET_TIMEOUT);
			$display("TEST FAILED");
			$finish;
		end
		else begin
			@(negedge clk4_2);
			assert (data_out === BOOT_PAT) else begin // address 0 after reset
				data_errs++;
				$display("ERROR %0t: data_out after reset is %h, expected %h", $time, data_out,
					BOOT_PAT);
			end
			run_vectors();
			$display("errors: data %0d, offset %0d, wr_en %0d, other %0d in %0d vectors",
				data_errs, offset_errs, wr_en_errs, other_errs, vectors);
			if (data_errs + offset_errs + wr_en_errs + other_errs == 0)
				$display("TEST OK");
			else
				$display("TEST FAILED");
			$finish;
		end
	end

endmodule

//--- mem_router_top.sv
`timescale 1ns/1ps

module mem_router_top #(
	parameter int unsigned BOOT_ROM_LAST_PAGE = 8 // 0 for the earlier console
) (
	input  logic                           clk4_2,
	input  logic                           reset_n,
	input  logic [mem_map_pkg::ADDR_W-1:0] addr,
	input  logic                           addr_latch,
	input  logic                           mem_we,
	input  logic [1:0]                     ext_ram_bank_sel,
	input  mem_map_pkg::io_regs_t          regs,
	input  mem_map_pkg::mem_rd_data_t      rd_src,
	output logic [mem_map_pkg::DATA_W-1:0] data_out,
	output mem_map_pkg::mem_wr_en_t        wr_en,
	output logic [mem_map_pkg::ADDR_W-1:0] addr_offset
);

	// registered cpu read path
	read_data_mux #(
		.BOOT_ROM_LAST_PAGE (BOOT_ROM_LAST_PAGE)
	) read_data_mux_inst (
		.clk4_2           (clk4_2),
		.reset_n          (reset_n),
		.addr             (addr),
		.addr_latch       (addr_latch),
		.ext_ram_bank_sel (ext_ram_bank_sel),
		.regs             (regs),
		.rd_src           (rd_src),
		.data_out         (data_out)
	);

	// live address with no latency
	write_enable_decoder #(
		.BOOT_ROM_LAST_PAGE (BOOT_ROM_LAST_PAGE)
	) write_enable_decoder_inst (
		.addr        (addr),
		.mem_we      (mem_we),
		.regs        (regs),
		.wr_en       (wr_en),
		.addr_offset (addr_offset)
	);

endmodule

//--- write_enable_decoder.sv
`timescale 1ns/1ps

module write_enable_decoder #(
	parameter int unsigned BOOT_ROM_LAST_PAGE = 8
) (
	input  logic [mem_map_pkg::ADDR_W-1:0] addr,
	input  logic                           mem_we,
	input  mem_map_pkg::io_regs_t          regs,
	output mem_map_pkg::mem_wr_en_t        wr_en,
	output logic [mem_map_pkg::ADDR_W-1:0] addr_offset
);

	import mem_map_pkg::*;

	mem_region_e wr_region;
	logic        in_echo;

	region_decoder #(
		.BOOT_ROM_LAST_PAGE (BOOT_ROM_LAST_PAGE)
	) region_decoder_inst (
		.addr   (addr),
		.region (wr_region),
		.offset (addr_offset)
	);

	// work ram regions above 0xDFFF can only come from the echo fold
	assign in_echo = (addr >= (WRAM0_BASE + ECHO_DELTA));

	always_comb begin
		wr_en = '0;
		if (mem_we) begin
			case (wr_region)
				VRAM: begin
					wr_en.vram[regs.vbk[0]] = 1'b1;
				end
				WRAM_FIXED: begin
					wr_en.wram[0] = !in_echo;
				end
				WRAM_BANKED: begin
					wr_en.wram[wram_bank_sel(regs.svbk)] = !in_echo;
				end
				HRAM: begin
					wr_en.hram = 1'b1;
				end
				default: begin
					wr_en = '0; // rom, cart ram, oam, io and ie are written elsewhere
				end
			endcase
		end
	end

endmodule

//--- read_data_mux.sv
`timescale 1ns/1ps

module read_data_mux #(
	parameter int unsigned BOOT_ROM_LAST_PAGE = 8
) (
	input  logic                           clk4_2,
	input  logic                           reset_n,
	input  logic [mem_map_pkg::ADDR_W-1:0] addr,
	input  logic                           addr_latch,
	input  logic [1:0]                     ext_ram_bank_sel,
	input  mem_map_pkg::io_regs_t          regs,
	input  mem_map_pkg::mem_rd_data_t      rd_src,
	output logic [mem_map_pkg::DATA_W-1:0] data_out
);

	import mem_map_pkg::*;

	logic [ADDR_W-1:0] rd_addr;
	mem_region_e       rd_region;
	logic [DATA_W-1:0] io_data;

	always_ff @(posedge clk4_2 or negedge reset_n) begin
		if (!reset_n) begin
			rd_addr <= '0;
		end
		else if (addr_latch) begin
			rd_addr <= addr;
		end
	end

	region_decoder #(
		.BOOT_ROM_LAST_PAGE (BOOT_ROM_LAST_PAGE)
	) region_decoder_inst (
		.addr   (rd_addr),
		.region (rd_region),
		.offset ()
	);

	io_reg_read io_reg_read_inst (
		.reg_addr         (rd_addr[7:0]),
		.regs             (regs),
		.bg_palette_data  (rd_src.bg_palette),
		.obj_palette_data (rd_src.obj_palette),
		.io_data          (io_data)
	);

	always_comb begin
		case (rd_region)
			BOOT_ROM_WIN: begin
				// overlay until software writes brlo
				data_out = (regs.brlo == '0) ? rd_src.boot_rom : rd_src.cart_rom;
			end
			CART_ROM: begin
				data_out = rd_src.cart_rom;
			end
			VRAM: begin
				data_out = rd_src.vram[regs.vbk[0]];
			end
			EXT_RAM: begin
				data_out = rd_src.ext_ram[ext_ram_bank_sel];
			end
			WRAM_FIXED: begin
				data_out = rd_src.wram[0];
			end
			WRAM_BANKED: begin
				data_out = rd_src.wram[wram_bank_sel(regs.svbk)];
			end
			OAM: begin
				data_out = rd_src.oam;
			end
			IO: begin
				data_out = io_data;
			end
			HRAM: begin
				data_out = rd_src.hram;
			end
			IE: begin
				data_out = regs.ie;
			end
			default: begin
				data_out = OPEN_BUS_DATA; // unusable range
			end
		endcase
	end

endmodule

//--- io_reg_read.sv
`timescale 1ns/1ps

module io_reg_read (
	input  logic [7:0]                     reg_addr,
	input  mem_map_pkg::io_regs_t          regs,
	input  logic [mem_map_pkg::DATA_W-1:0] bg_palette_data,
	input  logic [mem_map_pkg::DATA_W-1:0] obj_palette_data,
	output logic [mem_map_pkg::DATA_W-1:0] io_data
);

	import mem_map_pkg::*;

	always_comb begin
		case (reg_addr)
			JOYP:    io_data = regs.joyp;
			IF:      io_data = regs.int_flag;
			LCDC:    io_data = regs.lcdc;
			STAT:    io_data = regs.stat;
			SCY:     io_data = regs.scy;
			SCX:     io_data = regs.scx;
			LY:      io_data = regs.ly;
			LYC:     io_data = regs.lyc;
			WY:      io_data = regs.wy;
			WX:      io_data = regs.wx;
			VBK:     io_data = regs.vbk;
			BRLO:    io_data = regs.brlo;
			HDMA1:   io_data = regs.hdma1;
			HDMA2:   io_data = regs.hdma2;
			HDMA3:   io_data = regs.hdma3;
			HDMA4:   io_data = regs.hdma4;
			HDMA5:   io_data = regs.hdma5;
			BCPS:    io_data = regs.bcps;
			BCPD:    io_data = bg_palette_data; // palette ram behind index
			OCPS:    io_data = regs.ocps;
			OCPD:    io_data = obj_palette_data;
			SVBK:    io_data = regs.svbk;
			default: io_data = OPEN_BUS_DATA; // sound, serial, timer not routed here
		endcase
	end

endmodule

//--- region_decoder.sv
`timescale 1ns/1ps

module region_decoder #(
	parameter int unsigned BOOT_ROM_LAST_PAGE = 8
) (
	input  logic [mem_map_pkg::ADDR_W-1:0] addr,
	output mem_map_pkg::mem_region_e       region,
	output logic [mem_map_pkg::ADDR_W-1:0] offset
);

	import mem_map_pkg::*;

	logic [ADDR_W-1:0] mapped;
	logic [7:0]        page;
	logic              boot_page;

	assign page = addr[ADDR_W-1:ADDR_W-8];

	// page 0x01 holds the cartridge header and is never overlaid
	assign boot_page = (page <= BOOT_ROM_LAST_PAGE) && (page != 8'h01);

	always_comb begin
		mapped = addr;
		if (addr >= (WRAM0_BASE + ECHO_DELTA) && addr < OAM_BASE) begin
			mapped = addr - ECHO_DELTA; // echo folds back onto work ram
		end
	end

	always_comb begin
		region = CART_ROM;
		offset = mapped;
		if (mapped < VRAM_BASE) begin
			region = boot_page ? BOOT_ROM_WIN : CART_ROM;
		end
		else if (mapped < EXT_RAM_BASE) begin
			region = VRAM;
			offset = mapped - VRAM_BASE;
		end
		else if (mapped < WRAM0_BASE) begin
			region = EXT_RAM;
			offset = mapped - EXT_RAM_BASE;
		end
		else if (mapped < WRAMX_BASE) begin
			region = WRAM_FIXED;
			offset = mapped - WRAM0_BASE;
		end
		else if (mapped < OAM_BASE) begin
			region = WRAM_BANKED; // only 0xD000-0xDFFF gets here after folding
			offset = mapped - WRAMX_BASE;
		end
		else if (mapped < UNUSABLE_BASE) begin
			region = OAM;
			offset = mapped - OAM_BASE;
		end
		else if (mapped < IO_BASE) begin
			region = UNUSABLE;
			offset = mapped - UNUSABLE_BASE;
		end
		else if (mapped < HRAM_BASE) begin
			region = IO; // full address passed through
		end
		else if (mapped < IE_ADDR) begin
			region = HRAM;
			offset = mapped - HRAM_BASE;
		end
		else begin
			region = IE;
			offset = '0;
		end
	end

endmodule

//--- mem_map_pkg.sv
package mem_map_pkg;

	localparam int ADDR_W = 16;
	localparam int DATA_W = 8;

	localparam logic [DATA_W-1:0] OPEN_BUS_DATA = 8'hFF; // unusable and unmapped reads

	localparam logic [ADDR_W-1:0] VRAM_BASE     = 16'h8000;
	localparam logic [ADDR_W-1:0] EXT_RAM_BASE  = 16'hA000;
	localparam logic [ADDR_W-1:0] WRAM0_BASE    = 16'hC000;
	localparam logic [ADDR_W-1:0] WRAMX_BASE    = 16'hD000;
	localparam logic [ADDR_W-1:0] ECHO_DELTA    = 16'h2000; // echo sits this far above work ram
	localparam logic [ADDR_W-1:0] OAM_BASE      = 16'hFE00;
	localparam logic [ADDR_W-1:0] UNUSABLE_BASE = 16'hFEA0;
	localparam logic [ADDR_W-1:0] IO_BASE       = 16'hFF00;
	localparam logic [ADDR_W-1:0] HRAM_BASE     = 16'hFF80;
	localparam logic [ADDR_W-1:0] IE_ADDR       = 16'hFFFF;

	typedef enum logic [3:0] {
		BOOT_ROM_WIN,
		CART_ROM,
		VRAM,
		EXT_RAM,
		WRAM_FIXED,
		WRAM_BANKED,
		OAM,
		UNUSABLE,
		IO,
		HRAM,
		IE
	} mem_region_e;

	// low byte of the 0xFF00 page
	typedef enum logic [7:0] {
		JOYP  = 8'h00,
		IF    = 8'h0F,
		LCDC  = 8'h40,
		STAT  = 8'h41,
		SCY   = 8'h42,
		SCX   = 8'h43,
		LY    = 8'h44,
		LYC   = 8'h45,
		WY    = 8'h4A,
		WX    = 8'h4B,
		VBK   = 8'h4F,
		BRLO  = 8'h50,
		HDMA1 = 8'h51,
		HDMA2 = 8'h52,
		HDMA3 = 8'h53,
		HDMA4 = 8'h54,
		HDMA5 = 8'h55,
		BCPS  = 8'h68,
		BCPD  = 8'h69,
		OCPS  = 8'h6A,
		OCPD  = 8'h6B,
		SVBK  = 8'h70
	} io_reg_e;

	typedef struct packed {
		logic [DATA_W-1:0] joyp;
		logic [DATA_W-1:0] int_flag; // IF
		logic [DATA_W-1:0] lcdc;
		logic [DATA_W-1:0] stat;
		logic [DATA_W-1:0] scy;
		logic [DATA_W-1:0] scx;
		logic [DATA_W-1:0] ly;
		logic [DATA_W-1:0] lyc;
		logic [DATA_W-1:0] wy;
		logic [DATA_W-1:0] wx;
		logic [DATA_W-1:0] vbk;
		logic [DATA_W-1:0] brlo;
		logic [DATA_W-1:0] hdma1;
		logic [DATA_W-1:0] hdma2;
		logic [DATA_W-1:0] hdma3;
		logic [DATA_W-1:0] hdma4;
		logic [DATA_W-1:0] hdma5;
		logic [DATA_W-1:0] bcps;
		logic [DATA_W-1:0] ocps;
		logic [DATA_W-1:0] svbk;
		logic [DATA_W-1:0] ie;
	} io_regs_t;

	typedef struct packed {
		logic [DATA_W-1:0]       boot_rom;
		logic [DATA_W-1:0]       cart_rom;
		logic [1:0][DATA_W-1:0]  vram;
		logic [3:0][DATA_W-1:0]  ext_ram;
		logic [7:0][DATA_W-1:0]  wram;
		logic [DATA_W-1:0]       oam;
		logic [DATA_W-1:0]       hram;
		logic [DATA_W-1:0]       bg_palette;
		logic [DATA_W-1:0]       obj_palette;
	} mem_rd_data_t;

	typedef struct packed {
		logic [1:0] vram;
		logic [7:0] wram;
		logic       hram;
	} mem_wr_en_t;

	// svbk bank 0 maps onto bank 1
	function automatic logic [2:0] wram_bank_sel(input logic [DATA_W-1:0] svbk);
		logic [2:0] bank;
		bank = svbk[2:0];
		return (bank == 3'd0) ? 3'd1 : bank;
	endfunction

endpackage
